// File: sources.f
design/dcache_pkg.sv
design/dcache_req_buffer.sv
design/dcache_arrays.sv
design/dcache_ctrl.sv
design/dcache_mem_port.sv
design/dcache_top.sv
testbench/tb_dcache_mem.sv
testbench/tb_dcache.sv

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam logic [19:0] TAG_BASE = 20'h3a5c8;
    localparam int LIMIT    = 1000;
    localparam int LAT_ANY  = 0;
    localparam int LAT_HIT  = 1;
    localparam int LAT_MISS = 2;

    logic                 clk;
    logic                 rst;
    dcache_pkg::cpu_req_t cpu_req;
    dcache_pkg::cpu_rsp_t cpu_rsp;
    logic                 cpu_credit;
    dcache_pkg::mem_req_t mem_req;
    logic                 mem_credit;
    dcache_pkg::mem_rsp_t mem_rsp;

    int errors      = 0;
    int timeouts    = 0;
    int cycle       = 0;
    int credits_got = 0;
    int reqs_sent   = 0;
    int in_flight   = 0;
    int req_cycle   = 0;
    int wb_count    = 0;
    int mem_credits = dcache_pkg::MEM_CREDITS;
    logic [31:0] cur_addr;
    bit          dirty [128];
    dcache_pkg::cpu_rsp_t exp_q [$];
    int                   lat_q [$];

    dcache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req),
        .cpu_rsp_o    (cpu_rsp),
        .cpu_credit_o (cpu_credit),
        .mem_req_o    (mem_req),
        .mem_credit_i (mem_credit),
        .mem_rsp_i    (mem_rsp)
    );

    tb_dcache_mem #(.TAG_BASE(TAG_BASE)) u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_req_i    (mem_req),
        .mem_credit_o (mem_credit),
        .mem_rsp_o    (mem_rsp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] make_addr(
        input logic [2:0] t,
        input logic [3:0] s,
        input logic [1:0] w,
        input logic [1:0] b
    );
        return {TAG_BASE[19:3], t, 4'h0, s, w, b};
    endfunction

    function automatic int word_slot(input logic [31:0] addr);
        return {addr[14:12], addr[7:4], addr[3:2]};
    endfunction

    function automatic logic [31:0] line_addr(input int ls);
        return {TAG_BASE[19:3], ls[6:4], 4'h0, ls[3:0], 4'h0};
    endfunction

    function automatic logic [127:0] expected_line(input int ls);
        return {u_mem.ref_words[ls * 4 + 3], u_mem.ref_words[ls * 4 + 2],
                u_mem.ref_words[ls * 4 + 1], u_mem.ref_words[ls * 4]};
    endfunction

    // a load returns the current word and a store returns zero
    function automatic dcache_pkg::cpu_rsp_t expected_rsp(
        input logic [31:0] addr,
        input logic [3:0]  strb
    );
        dcache_pkg::cpu_rsp_t r;
        r.valid = 1'b1;
        r.rdata = (strb == 4'h0) ? u_mem.ref_words[word_slot(addr)] : 32'h0;
        return r;
    endfunction

    task automatic record_store(
        input logic [31:0] addr,
        input logic [3:0]  strb,
        input logic [31:0] wdata
    );
        int          k;
        logic [31:0] word;
        k    = word_slot(addr);
        word = u_mem.ref_words[k];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        u_mem.ref_words[k] = word;
        dirty[k / 4] = 1'b1;
    endtask

    task automatic check_rsp(input dcache_pkg::cpu_rsp_t got, input dcache_pkg::cpu_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR cpu_rsp_o: got valid %h rdata 0x%h, expected valid %h rdata 0x%h",
                     got.valid, got.rdata, exp.valid, exp.rdata);
        end
    endtask

    task automatic check_mem_req(input dcache_pkg::mem_req_t got,
                                 input dcache_pkg::mem_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR mem_req_o: got we %h addr 0x%h data 0x%h", got.we, got.addr,
                     got.data);
            $display("ERROR mem_req_o: expected we %h addr 0x%h data 0x%h", exp.we, exp.addr,
                     exp.data);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_run();
        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // once any wait has timed out no further requests go out
    task automatic issue(
        input logic [31:0] addr,
        input logic [3:0]  strb,
        input logic [31:0] wdata,
        input int          timing
    );
        int waited;
        waited = 0;
        while (timeouts == 0 && credits_got == reqs_sent && waited < LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (timeouts == 0 && credits_got == reqs_sent) begin
            timeouts++;
            $display("no CPU credit came back within %0d cycles", LIMIT);
        end else if (timeouts == 0) begin
            exp_q.push_back(expected_rsp(addr, strb));
            lat_q.push_back(timing);
            if (strb != 4'h0) begin
                record_store(addr, strb, wdata);
            end
            cur_addr          = addr;
            cpu_req.valid     = 1'b1;
            cpu_req.addr.raw  = addr;
            cpu_req.strb      = strb;
            cpu_req.wdata     = wdata;
            reqs_sent++;
            wait_cycles(1);
            cpu_req.valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (timeouts == 0 && exp_q.size() != 0 && waited < LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (timeouts == 0 && exp_q.size() != 0) begin
            timeouts++;
            $display("%0d CPU responses never arrived", exp_q.size());
        end
    endtask

    always @(posedge clk) begin : monitor
        dcache_pkg::cpu_rsp_t exp_rsp;
        dcache_pkg::mem_req_t exp_req;
        int kind;
        int lat;
        int ls;
        cycle = cycle + 1;
        if (!rst) begin
            // after the first credit one comes back with each response and never alone
            if (credits_got > 0 && cpu_credit !== cpu_rsp.valid) begin
                errors++;
                $display("ERROR cpu_credit_o: got %h, expected %h", cpu_credit, cpu_rsp.valid);
            end
            if (cpu_credit) begin
                credits_got++;
            end
            if (cpu_req.valid) begin
                in_flight++;
                req_cycle = cycle;
                if (in_flight > 1) begin
                    errors++;
                    $display("more than one CPU request in flight");
                end
            end
            if (cpu_rsp.valid) begin
                in_flight--;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("CPU response with no request waiting for it");
                end else begin
                    exp_rsp = exp_q.pop_front();
                    kind    = lat_q.pop_front();
                    lat     = cycle - req_cycle;
                    check_rsp(cpu_rsp, exp_rsp);
                    if ((kind == LAT_HIT && lat != 2) || (kind == LAT_MISS && lat <= 2)) begin
                        errors++;
                        $display("response came %0d cycles after its request, wrong for a %s",
                                 lat, (kind == LAT_HIT) ? "hit" : "miss");
                    end
                end
            end
            // the DUT decides on the count it held before this edge
            if (mem_req.valid) begin
                if (mem_credits == 0) begin
                    errors++;
                    $display("memory request sent with no credit left");
                end
                exp_req = mem_req;
                if (mem_req.we) begin
                    ls = {mem_req.addr[14:12], mem_req.addr[7:4]};
                    if (!dirty[ls]) begin
                        errors++;
                        $display("write-back of a line that holds no stored data");
                    end
                    dirty[ls] = 1'b0;
                    wb_count++;
                    exp_req.addr = line_addr(ls);
                    exp_req.data = expected_line(ls);
                end else begin
                    exp_req.addr = {cur_addr[31:4], 4'h0};
                end
                check_mem_req(mem_req, exp_req);
                mem_credits--;
            end
            if (mem_credit) begin
                mem_credits++;
            end
        end
    end

    initial begin
        logic [2:0]  t_sel;
        logic [3:0]  s_sel;
        logic [1:0]  w_sel;
        logic [1:0]  pos;
        logic [3:0]  strb;
        int          kind;
        clk     = 1'b0;
        rst     = 1'b1;
        cpu_req = '0;
        void'($urandom(32'hd1f0_0a2e));
        wait_cycles(2);
        rst = 1'b0;

        // cold miss, then a hit in the same line
        issue(make_addr(0, 3, 1, 0), 4'h0, 32'h0, LAT_MISS);
        issue(make_addr(0, 3, 2, 0), 4'h0, 32'h0, LAT_HIT);
        // byte, halfword and word stores on a resident line
        issue(make_addr(0, 3, 1, 2), 4'b0100, 32'h00a5_0000, LAT_HIT);
        issue(make_addr(0, 3, 1, 0), 4'h0, 32'h0, LAT_HIT);
        issue(make_addr(0, 3, 3, 2), 4'b1100, 32'hbeef_0000, LAT_HIT);
        issue(make_addr(0, 3, 3, 0), 4'h0, 32'h0, LAT_HIT);
        issue(make_addr(0, 3, 0, 0), 4'hf, 32'h1357_9bdf, LAT_HIT);
        issue(make_addr(0, 3, 0, 0), 4'h0, 32'h0, LAT_HIT);
        // write-allocate misses
        issue(make_addr(1, 5, 2, 1), 4'b0010, 32'h0000_3c00, LAT_MISS);
        issue(make_addr(1, 5, 2, 0), 4'h0, 32'h0, LAT_HIT);
        issue(make_addr(2, 6, 0, 0), 4'hf, 32'hcafe_f00d, LAT_MISS);
        issue(make_addr(2, 6, 0, 0), 4'h0, 32'h0, LAT_HIT);

        // three dirty lines on one set, two ways
        for (int t = 0; t < 3; t++) begin
            issue(make_addr(t, 9, t, 0), 4'hf, 32'h900d_0000 + t, LAT_MISS);
        end
        for (int t = 0; t < 3; t++) begin
            issue(make_addr(t, 9, t, 0), 4'h0, 32'h0, LAT_ANY);
        end
        drain();
        if (wb_count == 0) begin
            errors++;
            $display("no dirty line was written back on the crowded set");
        end

        // small sets and many tags keep evictions frequent
        for (int i = 0; i < 300; i++) begin
            t_sel = $urandom_range(7, 0);
            s_sel = $urandom_range(3, 0);
            w_sel = $urandom_range(3, 0);
            pos   = $urandom_range(3, 0);
            kind  = $urandom_range(3, 0);
            case (kind)
                0: begin
                    pos  = 2'd0;
                    strb = 4'h0;
                end
                1: strb = 4'b0001 << pos;
                2: begin
                    pos  = pos & 2'b10;
                    strb = 4'b0011 << pos;
                end
                default: begin
                    pos  = 2'd0;
                    strb = 4'hf;
                end
            endcase
            issue(make_addr(t_sel, s_sel, w_sel, pos), strb, $urandom(), LAT_ANY);
        end
        drain();
        end_run();
    end

endmodule

`default_nettype wire

// File: testbench/tb_dcache_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_mem #(
    parameter logic [19:0] TAG_BASE = 20'h0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::mem_req_t mem_req_i,
    output logic                 mem_credit_o,
    output dcache_pkg::mem_rsp_t mem_rsp_o
);

    // word k of the test region is tag_sel k[8:6], set k[5:2], word k[1:0]
    logic [31:0]  ref_words [512];
    logic [127:0] lines [128];
    dcache_pkg::mem_req_t req_q [$];
    int credit_due = 0;

    function automatic logic [31:0] slot_addr(input int k);
        logic [8:0] s;
        s = k[8:0];
        return {TAG_BASE[19:3], s[8:6], 4'h0, s[5:2], s[1:0], 2'b00};
    endfunction

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
    endfunction

    function automatic int line_slot(input logic [31:0] addr);
        return {addr[14:12], addr[7:4]};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        mem_credit_o = 1'b0;
        mem_rsp_o    = '0;
        for (int k = 0; k < 512; k++) begin
            ref_words[k] = pattern_word(slot_addr(k));
            lines[k / 4][(k % 4) * 32 +: 32] = ref_words[k];
        end
    end

    always @(posedge clk) begin
        if (!rst && mem_req_i.valid) begin
            req_q.push_back(mem_req_i);
        end
    end

    // requests are taken one at a time and in arrival order
    initial begin : serve
        dcache_pkg::mem_req_t req;
        forever begin
            wait_cycles(1);
            if (req_q.size() != 0) begin
                req = req_q.pop_front();
                wait_cycles($urandom_range(3, 0));
                credit_due++;
                if (req.we) begin
                    lines[line_slot(req.addr)] = req.data;
                end else begin
                    wait_cycles($urandom_range(4, 0));
                    mem_rsp_o.data  = lines[line_slot(req.addr)];
                    mem_rsp_o.valid = 1'b1;
                    wait_cycles(1);
                    mem_rsp_o.valid = 1'b0;
                end
            end
        end
    end

    // a taken request hands its credit back after a random stall
    initial begin : grant
        forever begin
            wait_cycles(1);
            if (credit_due != 0) begin
                wait_cycles($urandom_range(8, 0));
                credit_due--;
                mem_credit_o = 1'b1;
                wait_cycles(1);
                mem_credit_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output dcache_pkg::cpu_rsp_t cpu_rsp_o,
    output logic                 cpu_credit_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_credit_i,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);

    dcache_pkg::cpu_req_t                                    req;
    logic [dcache_pkg::INDEX_W-1:0]                          index;
    logic [dcache_pkg::NWAY-1:0]                             tag_we;
    dcache_pkg::tag_entry_t                                  tag_wdata;
    logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_BYTES-1:0] line_be;
    logic [dcache_pkg::LINE_W-1:0]                           line_wdata;
    dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0]           tag_rdata;
    logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_W-1:0]     line_rdata;
    logic                                                    init_done;
    dcache_pkg::mem_req_t                                    ctrl_mem_req;
    logic                                                    mem_accept;
    dcache_pkg::mem_rsp_t                                    refill;

    dcache_req_buffer u_req_buffer (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .rsp_done_i   (cpu_rsp_o.valid),
        .req_o        (req),
        .cpu_credit_o (cpu_credit_o),
        .init_done_i  (init_done)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .tag_rdata_i  (tag_rdata),
        .line_rdata_i (line_rdata),
        .index_o      (index),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .line_be_o    (line_be),
        .line_wdata_o (line_wdata),
        .mem_req_o    (ctrl_mem_req),
        .mem_accept_i (mem_accept),
        .refill_i     (refill),
        .rsp_o        (cpu_rsp_o)
    );

    dcache_arrays u_arrays (
        .clk          (clk),
        .rst          (rst),
        .index_i      (index),
        .tag_we_i     (tag_we),
        .tag_wdata_i  (tag_wdata),
        .line_be_i    (line_be),
        .line_wdata_i (line_wdata),
        .tag_rdata_o  (tag_rdata),
        .line_rdata_o (line_rdata),
        .init_done_o  (init_done)
    );

    dcache_mem_port u_mem_port (
        .clk          (clk),
        .rst          (rst),
        .req_i        (ctrl_mem_req),
        .accept_o     (mem_accept),
        .mem_req_o    (mem_req_o),
        .mem_credit_i (mem_credit_i),
        .mem_rsp_i    (mem_rsp_i),
        .refill_o     (refill)
    );

endmodule

`default_nettype wire

// File: design/dcache_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_port (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::mem_req_t req_i,
    output logic                 accept_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_credit_i,
    input  dcache_pkg::mem_rsp_t mem_rsp_i,
    output dcache_pkg::mem_rsp_t refill_o
);

    typedef logic [$clog2(dcache_pkg::MEM_CREDITS + 1)-1:0] credit_cnt_t;

    credit_cnt_t credits;
    logic        send;

    // request passes through in the cycle a credit is there
    assign send     = req_i.valid && (credits != '0);
    assign accept_o = send;

    always_comb begin
        mem_req_o       = req_i;
        mem_req_o.valid = send;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_cnt_t'(dcache_pkg::MEM_CREDITS);
        end else begin
            case ({mem_credit_i, send})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ctrl sees the registered refill one cycle after mem_rsp_i
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_o.valid <= 1'b0;
        end else begin
            refill_o.valid <= mem_rsp_i.valid;
        end
        if (mem_rsp_i.valid) begin
            refill_o.data <= mem_rsp_i.data;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  dcache_pkg::cpu_req_t                                    req_i,
    input  dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0]           tag_rdata_i,
    input  logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_W-1:0]     line_rdata_i,
    output logic [dcache_pkg::INDEX_W-1:0]                          index_o,
    output logic [dcache_pkg::NWAY-1:0]                             tag_we_o,
    output dcache_pkg::tag_entry_t                                  tag_wdata_o,
    output logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_BYTES-1:0] line_be_o,
    output logic [dcache_pkg::LINE_W-1:0]                           line_wdata_o,
    output dcache_pkg::mem_req_t                                    mem_req_o,
    input  logic                                                    mem_accept_i,
    input  dcache_pkg::mem_rsp_t                                    refill_i,
    output dcache_pkg::cpu_rsp_t                                    rsp_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_REFILL_REQ,
        S_REFILL_WAIT
    } state_t;

    state_t                            state;
    state_t                            state_next;
    logic [dcache_pkg::NWAY-1:0]       way_hit;
    logic                              hit;
    logic                              hit_way;
    logic                              is_store;
    logic [1:0]                        word_sel;
    logic [15:0]                       lfsr;
    logic                              victim_q;
    logic [dcache_pkg::WORD_W-1:0]     hit_word;
    logic [dcache_pkg::WORD_W-1:0]     refill_word;
    logic [dcache_pkg::LINE_W-1:0]     refill_line;
    logic [dcache_pkg::LINE_BYTES-1:0] store_be;

    function automatic logic [dcache_pkg::WORD_W-1:0] merge_word(
        input logic [dcache_pkg::WORD_W-1:0] old_word,
        input logic [dcache_pkg::WORD_W-1:0] wdata,
        input logic [3:0]                    strb
    );
        logic [dcache_pkg::WORD_W-1:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // index stays on the held request, so array reads are stable for the whole miss
    assign index_o  = req_i.addr.f.index;
    assign is_store = |req_i.strb;
    assign word_sel = req_i.addr.f.offset[3:2];
    assign store_be = {{(dcache_pkg::LINE_BYTES - 4){1'b0}}, req_i.strb} << {word_sel, 2'b00};

    always_comb begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            way_hit[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == req_i.addr.f.tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_word = line_rdata_i[hit_way][word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

    // write-allocate merge leaves the refill word untouched for a load
    assign refill_word = refill_i.data[word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    always_comb begin
        refill_line = refill_i.data;
        refill_line[word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] =
            merge_word(refill_word, req_i.wdata, req_i.strb);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            lfsr  <= dcache_pkg::LFSR_SEED;
        end else begin
            state <= state_next;
            // taps 16,14,13,11
            lfsr  <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
        if (state == S_LOOKUP) begin
            victim_q <= lfsr[0];
        end
    end

    always_comb begin
        state_next   = state;
        tag_we_o     = '0;
        tag_wdata_o  = '0;
        line_be_o    = '0;
        line_wdata_o = refill_line;
        mem_req_o    = '0;
        rsp_o        = '0;
        case (state)
            S_IDLE: begin
                if (req_i.valid) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    rsp_o.valid = 1'b1;
                    state_next  = S_IDLE;
                    if (is_store) begin
                        tag_we_o[hit_way]  = 1'b1;
                        tag_wdata_o        = '{dirty: 1'b1, valid: 1'b1, tag: req_i.addr.f.tag};
                        line_be_o[hit_way] = store_be;
                        line_wdata_o = {(dcache_pkg::LINE_W / dcache_pkg::WORD_W){req_i.wdata}};
                    end else begin
                        rsp_o.rdata = hit_word;
                    end
                end else if (tag_rdata_i[lfsr[0]].valid && tag_rdata_i[lfsr[0]].dirty) begin
                    state_next = S_WRITEBACK;
                end else begin
                    state_next = S_REFILL_REQ;
                end
            end
            S_WRITEBACK: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.we    = 1'b1;
                mem_req_o.addr  = {tag_rdata_i[victim_q].tag, req_i.addr.f.index,
                                   {dcache_pkg::OFFSET_W{1'b0}}};
                mem_req_o.data  = line_rdata_i[victim_q];
                if (mem_accept_i) begin
                    state_next = S_REFILL_REQ;
                end
            end
            S_REFILL_REQ: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.addr  = {req_i.addr.f.tag, req_i.addr.f.index,
                                   {dcache_pkg::OFFSET_W{1'b0}}};
                if (mem_accept_i) begin
                    state_next = S_REFILL_WAIT;
                end
            end
            S_REFILL_WAIT: begin
                if (refill_i.valid) begin
                    tag_we_o[victim_q]  = 1'b1;
                    tag_wdata_o = '{dirty: is_store, valid: 1'b1, tag: req_i.addr.f.tag};
                    line_be_o[victim_q] = '1;
                    rsp_o.valid = 1'b1;
                    rsp_o.rdata = is_store ? '0 : refill_word;
                    state_next  = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/dcache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_arrays (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [dcache_pkg::INDEX_W-1:0]                         index_i,
    input  logic [dcache_pkg::NWAY-1:0]                            tag_we_i,
    input  dcache_pkg::tag_entry_t                                 tag_wdata_i,
    input  logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_BYTES-1:0] line_be_i,
    input  logic [dcache_pkg::LINE_W-1:0]                          line_wdata_i,
    output dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0]          tag_rdata_o,
    output logic [dcache_pkg::NWAY-1:0][dcache_pkg::LINE_W-1:0]    line_rdata_o,
    output logic                                                   init_done_o
);

    dcache_pkg::tag_entry_t           tag_mem [dcache_pkg::NWAY][dcache_pkg::NSET];
    logic [dcache_pkg::LINE_W-1:0]    line_mem [dcache_pkg::NWAY][dcache_pkg::NSET];
    logic [dcache_pkg::INDEX_W-1:0]   sweep_idx;

    // walk every set once after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_idx   <= '0;
            init_done_o <= 1'b0;
        end else if (!init_done_o) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                init_done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            if (!init_done_o) begin
                tag_mem[w][sweep_idx] <= '0;
            end else if (tag_we_i[w]) begin
                tag_mem[w][index_i] <= tag_wdata_i;
            end
            for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
                if (line_be_i[w][b]) begin
                    line_mem[w][index_i][b*8 +: 8] <= line_wdata_i[b*8 +: 8];
                end
            end
            // read returns the old contents on a same-cycle write
            tag_rdata_o[w]  <= tag_mem[w][index_i];
            line_rdata_o[w] <= line_mem[w][index_i];
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_req_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    input  logic                 rsp_done_i,
    output dcache_pkg::cpu_req_t req_o,
    output logic                 cpu_credit_o,
    input  logic                 init_done_i
);

    logic init_done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_o.valid <= 1'b0;
            init_done_q <= 1'b0;
        end else begin
            init_done_q <= init_done_i;
            // a new request can only arrive after the previous response
            if (cpu_req_i.valid) begin
                req_o.valid <= 1'b1;
            end else if (rsp_done_i) begin
                req_o.valid <= 1'b0;
            end
        end
        if (cpu_req_i.valid) begin
            req_o.addr  <= cpu_req_i.addr;
            req_o.strb  <= cpu_req_i.strb;
            req_o.wdata <= cpu_req_i.wdata;
        end
    end

    // first credit once the valid sweep is over, then one per response
    assign cpu_credit_o = (init_done_i & ~init_done_q) | rsp_done_i;

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;
    localparam int LINE_BYTES = LINE_W / 8;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W = 8;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NSET = 1 << INDEX_W;
    localparam int NWAY = 2;
    localparam int MEM_CREDITS = 2;
    localparam logic [15:0] LFSR_SEED = 16'hace1;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // same word seen raw or split by the address layout
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } dcache_addr_u;

    // strb of zero is a load
    typedef struct packed {
        logic              valid;
        dcache_addr_u      addr;
        logic [3:0]        strb;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic             dirty;
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire
